// File: common/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // one quarter of an SCL period lasts 2**I2C_CLK_DIV_BITS clk cycles.
    localparam int unsigned I2C_CLK_DIV_BITS = 2;

    // a single addressed write of one register byte and two data bytes.
    typedef struct packed {
        logic [6:0] dev_addr;
        logic [7:0] cmd;
        logic [7:0] data_lo;
        logic [7:0] data_hi;
    } i2c_wr_req_t;

    // the bus level is sda while sda_oe_n is low, pulled up otherwise.
    typedef struct packed {
        logic scl;
        logic sda;
        logic sda_oe_n;
    } i2c_pins_t;

    typedef enum logic [2:0] {
        IDLE,
        START,
        BIT,
        ACK,
        STOP
    } i2c_state_e;

endpackage

`default_nettype wire

// File: common/ioexp_pkg.sv
`default_nettype none

package ioexp_pkg;

    // ****************************************
    // PCAL6416A devices and commands
    // ****************************************

    localparam logic [6:0] EXP0_ADDR = 7'h20;
    localparam logic [6:0] EXP1_ADDR = 7'h21;

    localparam logic [7:0] CMD_OUTPUT = 8'h02;
    localparam logic [7:0] CMD_CONFIG = 8'h06;

    // ****************************************
    // APB register map
    // ****************************************

    localparam logic [3:0] REG_OUT0   = 4'h0;
    localparam logic [3:0] REG_OUT1   = 4'h4;
    localparam logic [3:0] REG_STATUS = 4'h8;

    typedef struct packed {
        logic [3:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [15:0] out0;
        logic [15:0] out1;
    } ioexp_out_t;

    typedef enum logic [2:0] {
        CFG0,
        CFG0_WAIT,
        CFG1,
        CFG1_WAIT,
        IDLE,
        SEND,
        SEND_WAIT
    } ioexp_state_e;

endpackage

`default_nettype wire

// File: hw/ioexp_apb_regs.sv
`default_nettype none

module ioexp_apb_regs (
    input  wire                    clk,
    input  wire                    reset,
    input  wire ioexp_pkg::apb_req_t apb_req,
    output ioexp_pkg::apb_rsp_t    apb_rsp,
    input  wire                    busy,
    output ioexp_pkg::ioexp_out_t  outputs
);

    logic access;
    logic wr_en;
    logic addr_err;

    // zero wait states, so every access phase completes on its first cycle.
    assign access = apb_req.psel && apb_req.penable;
    assign wr_en  = access && apb_req.pwrite;

    always_ff @(posedge clk) begin
        if (reset) begin
            outputs <= '0;
        end else if (wr_en) begin
            case (apb_req.paddr)
                ioexp_pkg::REG_OUT0: outputs.out0 <= apb_req.pwdata[15:0];
                ioexp_pkg::REG_OUT1: outputs.out1 <= apb_req.pwdata[15:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        apb_rsp.prdata = '0;
        addr_err       = 1'b0;
        case (apb_req.paddr)
            ioexp_pkg::REG_OUT0: begin
                apb_rsp.prdata = {16'h0000, outputs.out0};
            end
            ioexp_pkg::REG_OUT1: begin
                apb_rsp.prdata = {16'h0000, outputs.out1};
            end
            ioexp_pkg::REG_STATUS: begin
                // status is read only.
                apb_rsp.prdata = {31'h0, busy};
                addr_err       = apb_req.pwrite;
            end
            default: begin
                addr_err = 1'b1;
            end
        endcase
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && addr_err;
    end

    // ****************************************
    // protocol checks
    // ****************************************

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset)
        apb_req.penable |-> apb_req.psel
    );

endmodule

`default_nettype wire

// File: i2c_ioexp/i2c_master_wr.sv
`default_nettype none

module i2c_master_wr (
    input  wire                      clk,
    input  wire                      reset,
    input  wire i2c_pkg::i2c_wr_req_t req,
    input  wire                      start,
    output logic                     done,
    output i2c_pkg::i2c_pins_t       pins
);

    i2c_pkg::i2c_state_e state;

    // top two bits select the quarter, the rest divide clk.
    logic [i2c_pkg::I2C_CLK_DIV_BITS+1:0] cnt;
    logic [1:0]  quarter;
    logic        slot_end;

    logic [2:0]  bit_cnt;
    logic [1:0]  byte_cnt;
    logic [31:0] sreg;

    i2c_pkg::i2c_pins_t pins_d;

    assign quarter  = cnt[i2c_pkg::I2C_CLK_DIV_BITS+1 -: 2];
    assign slot_end = &cnt;

    // ****************************************
    // pin levels per state and quarter
    // ****************************************

    always_comb begin
        pins_d.scl      = 1'b1;
        pins_d.sda      = 1'b1;
        pins_d.sda_oe_n = 1'b0;
        case (state)
            i2c_pkg::START: begin
                pins_d.sda = (quarter < 2'd2);
                pins_d.scl = (quarter != 2'd3);
            end
            i2c_pkg::BIT: begin
                pins_d.sda = sreg[31];
                pins_d.scl = quarter[0] ^ quarter[1];
            end
            i2c_pkg::ACK: begin
                // release sda so the device can drive its acknowledge.
                pins_d.sda_oe_n = 1'b1;
                pins_d.scl      = quarter[0] ^ quarter[1];
            end
            i2c_pkg::STOP: begin
                pins_d.sda = (quarter >= 2'd2);
                pins_d.scl = (quarter != 2'd0);
            end
            default: ;
        endcase
    end

    // ****************************************
    // frame sequencing
    // ****************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= i2c_pkg::IDLE;
            cnt      <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            done     <= 1'b0;
            pins     <= '{scl: 1'b1, sda: 1'b1, sda_oe_n: 1'b0};
        end else begin
            done <= 1'b0;
            pins <= pins_d;
            if (state != i2c_pkg::IDLE) begin
                cnt <= cnt + 1'b1;
            end
            case (state)
                i2c_pkg::IDLE: begin
                    if (start) begin
                        cnt      <= '0;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                        state    <= i2c_pkg::START;
                    end
                end
                i2c_pkg::START: begin
                    if (slot_end) state <= i2c_pkg::BIT;
                end
                i2c_pkg::BIT: begin
                    if (slot_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= i2c_pkg::ACK;
                        end
                    end
                end
                i2c_pkg::ACK: begin
                    if (slot_end) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        state    <= (byte_cnt == 2'd3) ? i2c_pkg::STOP : i2c_pkg::BIT;
                    end
                end
                i2c_pkg::STOP: begin
                    if (slot_end) begin
                        done  <= 1'b1;
                        state <= i2c_pkg::IDLE;
                    end
                end
                default: state <= i2c_pkg::IDLE;
            endcase
        end
    end

    // address with R/W low, then the three bytes, msb first.
    always_ff @(posedge clk) begin
        if (state == i2c_pkg::IDLE && start) begin
            sreg <= {req.dev_addr, 1'b0, req.cmd, req.data_lo, req.data_hi};
        end else if (state == i2c_pkg::BIT && slot_end) begin
            sreg <= {sreg[30:0], 1'b0};
        end
    end

    // pins lag state by one cycle, hence the past state in the exception.
    a_sda_stable_scl_high: assert property (
        @(posedge clk) disable iff (reset)
        $changed(pins.sda) |->
            (!pins.scl && !$past(pins.scl)) ||
            ($past(state) inside {i2c_pkg::START, i2c_pkg::STOP})
    );

endmodule

`default_nettype wire

// File: i2c_ioexp/i2c_ioexp.sv
`default_nettype none

module i2c_ioexp (
    input  wire                       clk,
    input  wire                       reset,
    input  wire ioexp_pkg::ioexp_out_t outputs,
    output logic                      busy,
    output i2c_pkg::i2c_wr_req_t      req,
    output logic                      start,
    input  wire                       done
);

    ioexp_pkg::ioexp_state_e state;

    // values last sent to each expander.
    logic [15:0] last0;
    logic [15:0] last1;

    assign busy = (state != ioexp_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ioexp_pkg::CFG0;
            start <= 1'b0;
            // inverse of the register reset value, so zeros go out after config.
            last0 <= '1;
            last1 <= '1;
        end else begin
            case (state)
                // a zero config byte makes the pin an output.
                ioexp_pkg::CFG0: begin
                    req.dev_addr <= ioexp_pkg::EXP0_ADDR;
                    req.cmd      <= ioexp_pkg::CMD_CONFIG;
                    req.data_lo  <= 8'h00;
                    req.data_hi  <= 8'h00;
                    start        <= 1'b1;
                    state        <= ioexp_pkg::CFG0_WAIT;
                end
                ioexp_pkg::CFG0_WAIT: begin
                    start <= 1'b0;
                    if (done) begin
                        state <= ioexp_pkg::CFG1;
                    end
                end
                ioexp_pkg::CFG1: begin
                    req.dev_addr <= ioexp_pkg::EXP1_ADDR;
                    req.cmd      <= ioexp_pkg::CMD_CONFIG;
                    req.data_lo  <= 8'h00;
                    req.data_hi  <= 8'h00;
                    start        <= 1'b1;
                    state        <= ioexp_pkg::CFG1_WAIT;
                end
                ioexp_pkg::CFG1_WAIT: begin
                    start <= 1'b0;
                    if (done) begin
                        state <= ioexp_pkg::IDLE;
                    end
                end
                // expander 0 is checked first and so wins a tie.
                ioexp_pkg::IDLE: begin
                    if (outputs.out0 != last0) begin
                        last0        <= outputs.out0;
                        req.dev_addr <= ioexp_pkg::EXP0_ADDR;
                        req.cmd      <= ioexp_pkg::CMD_OUTPUT;
                        req.data_lo  <= outputs.out0[7:0];
                        req.data_hi  <= outputs.out0[15:8];
                        state        <= ioexp_pkg::SEND;
                    end else if (outputs.out1 != last1) begin
                        last1        <= outputs.out1;
                        req.dev_addr <= ioexp_pkg::EXP1_ADDR;
                        req.cmd      <= ioexp_pkg::CMD_OUTPUT;
                        req.data_lo  <= outputs.out1[7:0];
                        req.data_hi  <= outputs.out1[15:8];
                        state        <= ioexp_pkg::SEND;
                    end
                end
                ioexp_pkg::SEND: begin
                    start <= 1'b1;
                    state <= ioexp_pkg::SEND_WAIT;
                end
                ioexp_pkg::SEND_WAIT: begin
                    start <= 1'b0;
                    if (done) begin
                        state <= ioexp_pkg::IDLE;
                    end
                end
                default: begin
                    start <= 1'b0;
                    state <= ioexp_pkg::IDLE;
                end
            endcase
        end
    end

    a_start_pulse: assert property (
        @(posedge clk) disable iff (reset)
        start |-> (state != ioexp_pkg::IDLE) ##1 !start
    );

endmodule

`default_nettype wire

// File: hw/ioexp_subsys_top.sv
`default_nettype none

module ioexp_subsys_top (
    input  wire                      clk,
    input  wire                      reset,
    input  wire ioexp_pkg::apb_req_t apb_req,
    output ioexp_pkg::apb_rsp_t      apb_rsp,
    output i2c_pkg::i2c_pins_t       pins
);

    ioexp_pkg::ioexp_out_t outputs;
    i2c_pkg::i2c_wr_req_t  req;
    logic                  busy;
    logic                  start;
    logic                  done;

    ioexp_apb_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .busy    (busy),
        .outputs (outputs)
    );

    i2c_ioexp u_seq (
        .clk     (clk),
        .reset   (reset),
        .outputs (outputs),
        .busy    (busy),
        .req     (req),
        .start   (start),
        .done    (done)
    );

    i2c_master_wr u_master (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .start (start),
        .done  (done),
        .pins  (pins)
    );

endmodule

`default_nettype wire

// File: verif/ioexp_checker.sv
`default_nettype none

module ioexp_checker (
    input  wire                      clk,
    input  wire                      reset,
    input  wire ioexp_pkg::apb_req_t apb_req,
    input  wire ioexp_pkg::apb_rsp_t apb_rsp,
    input  wire i2c_pkg::i2c_pins_t  pins,
    output int unsigned              frame_errors,
    output int unsigned              apb_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    i2c_pkg::i2c_wr_req_t frame_q[$];
    // each entry is {check read data, expected pslverr, expected prdata}.
    logic [33:0]          apb_q[$];
    logic [33:0]          apb_exp;

    logic                 sda_bus;
    logic                 scl_q;
    logic                 sda_q;
    logic                 in_frame;
    logic [35:0]          bits;
    // a one marks a bit slot in which the master released sda.
    logic [35:0]          rel;
    int unsigned          nbits;

    assign sda_bus = pins.sda_oe_n | pins.sda;

    task expect_frame(input i2c_pkg::i2c_wr_req_t f);
        frame_q.push_back(f);
    endtask

    task expect_apb(input logic chk, input logic err, input logic [31:0] data);
        apb_q.push_back({chk, err, data});
    endtask

    function int unsigned frames_left();
        return frame_q.size();
    endfunction

    // ****************************************
    // I2C frame decoding
    // ****************************************

    // the stop condition begins with one more rising scl, so a frame has 37 clocks.
    task automatic check_frame(input logic [35:0] got, input logic [35:0] got_rel,
                               input int unsigned n);
        i2c_pkg::i2c_wr_req_t f;
        logic [35:0]          want;
        logic [35:0]          want_rel;
        if (frame_q.size() == 0) begin
            $display("an I2C frame arrived at %0t that no row expected", $time);
            frame_errors++;
        end else begin
            f        = frame_q.pop_front();
            want     = {f.dev_addr, 1'b0, 1'b1, f.cmd, 1'b1, f.data_lo, 1'b1, f.data_hi, 1'b1};
            // every byte is driven for eight slots, then sda is let go for the acknowledge.
            want_rel = {4{9'h001}};
            if (n != 37 || got !== want) begin
                $display("ERR %0t: frame %h with %0d clocks, expected %h", $time, got, n, want);
                frame_errors++;
            end
            if (got_rel !== want_rel) begin
                $display("ERR %0t: sda released in slots %h, expected %h", $time,
                         got_rel, want_rel);
                frame_errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
            in_frame <= 1'b0;
            nbits    <= 0;
        end else begin
            scl_q <= pins.scl;
            sda_q <= sda_bus;
            if (pins.scl && scl_q && sda_q && !sda_bus) begin
                in_frame <= 1'b1;
                nbits    <= 0;
            end else if (pins.scl && scl_q && !sda_q && sda_bus && in_frame) begin
                in_frame <= 1'b0;
                check_frame(bits, rel, nbits);
            end else if (pins.scl && !scl_q && in_frame) begin
                if (nbits < 36) begin
                    bits <= {bits[34:0], sda_bus};
                    rel  <= {rel[34:0], pins.sda_oe_n};
                end
                nbits <= nbits + 1;
            end
        end
    end

    // ****************************************
    // APB responses
    // ****************************************

    always @(posedge clk) begin
        if (!reset && apb_req.psel && apb_req.penable && apb_q.size() != 0) begin
            apb_exp = apb_q.pop_front();
            if (apb_rsp.pready !== 1'b1) begin
                $display("ERR %0t: pready low in the access phase", $time);
                apb_errors++;
            end
            if (apb_rsp.pslverr !== apb_exp[32]) begin
                $display("ERR %0t: pslverr %b at offset %h, expected %b", $time,
                         apb_rsp.pslverr, apb_req.paddr, apb_exp[32]);
                apb_errors++;
            end
            if (apb_exp[33] && apb_rsp.prdata !== apb_exp[31:0]) begin
                $display("ERR %0t: read %h at offset %h, expected %h", $time,
                         apb_rsp.prdata, apb_req.paddr, apb_exp[31:0]);
                apb_errors++;
            end
        end
    end

    task final_check();
        if (frame_q.size() != 0) begin
            $display("%0d expected I2C frames never arrived", frame_q.size());
            frame_errors += frame_q.size();
        end
        if (apb_q.size() != 0) begin
            $display("%0d expected APB accesses never took place", apb_q.size());
            apb_errors += apb_q.size();
        end
    endtask

endmodule

`default_nettype wire

// File: verif/tb_ioexp.sv
`default_nettype none

module tb_ioexp;
    timeunit 1ns;
    timeprecision 1ps;

    // 16 table rows plus the four start-up frames, 700 cycles each.
    localparam int unsigned TIMEOUT_CYCLES = (16 + 4) * 700;

    typedef struct packed {
        logic        wr;
        logic [3:0]  addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        exp_err;
        logic        has_frame;
        logic [6:0]  dev;
        logic        wait_after;
    } row_t;

    logic                clk = 1'b0;
    logic                reset;
    ioexp_pkg::apb_req_t apb_req;
    ioexp_pkg::apb_rsp_t apb_rsp;
    i2c_pkg::i2c_pins_t  pins;
    int unsigned         frame_errors;
    int unsigned         apb_errors;
    int unsigned         cycles = 0;
    row_t                rows[$];

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    ioexp_subsys_top u_ioexp_subsys_top (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .pins    (pins)
    );

    ioexp_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .pins         (pins),
        .frame_errors (frame_errors),
        .apb_errors   (apb_errors)
    );

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        @(negedge clk);
        apb_req.paddr   = addr;
        apb_req.pwrite  = wr;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #10;
        rdata = apb_rsp.prdata;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    // idle means the sequencer is done and every expected frame has been seen.
    task automatic wait_idle();
        logic [31:0] rd;
        do begin
            apb_access(1'b0, ioexp_pkg::REG_STATUS, 32'h0, rd);
        end while (rd[0] || u_checker.frames_left() != 0);
    endtask

    task automatic add_row(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp_rdata, input logic exp_err,
                           input logic has_frame, input logic [6:0] dev, input logic wait_after);
        rows.push_back({wr, addr, wdata, exp_rdata, exp_err, has_frame, dev, wait_after});
    endtask

    function automatic logic [15:0] fresh_value(input logic [15:0] old);
        logic [15:0] v;
        v = $urandom;
        if (v == old) begin
            v = ~old;
        end
        return v;
    endfunction

    initial begin
        logic [15:0] r0a;
        logic [15:0] r1a;
        logic [15:0] r0b;
        logic [15:0] r1b;
        logic [15:0] r1c;
        logic [31:0] rd;
        void'($urandom(84936));
        reset   = 1'b1;
        apb_req = '0;

        u_checker.expect_frame({ioexp_pkg::EXP0_ADDR, ioexp_pkg::CMD_CONFIG, 16'h0000});
        u_checker.expect_frame({ioexp_pkg::EXP1_ADDR, ioexp_pkg::CMD_CONFIG, 16'h0000});
        u_checker.expect_frame({ioexp_pkg::EXP0_ADDR, ioexp_pkg::CMD_OUTPUT, 16'h0000});
        u_checker.expect_frame({ioexp_pkg::EXP1_ADDR, ioexp_pkg::CMD_OUTPUT, 16'h0000});

        r0a = fresh_value(16'h0000);
        r1a = fresh_value(16'h0000);
        r0b = fresh_value(r0a);
        r1b = fresh_value(r1a);
        r1c = fresh_value(r1b);

        // wr, offset, write data, read data, pslverr, frame, address, wait for idle.
        add_row(1, ioexp_pkg::REG_OUT0, {16'($urandom), r0a}, 0, 0, 1, ioexp_pkg::EXP0_ADDR, 1);
        add_row(0, ioexp_pkg::REG_OUT0, 0, {16'h0, r0a}, 0, 0, 0, 1);
        add_row(1, ioexp_pkg::REG_OUT1, {16'($urandom), r1a}, 0, 0, 1, ioexp_pkg::EXP1_ADDR, 1);
        add_row(0, ioexp_pkg::REG_OUT1, 0, {16'h0, r1a}, 0, 0, 0, 1);
        add_row(1, ioexp_pkg::REG_OUT0, {16'($urandom), r0a}, 0, 0, 0, 0, 1);
        add_row(1, ioexp_pkg::REG_OUT1, {16'h0, r1a}, 0, 0, 0, 0, 1);
        add_row(1, 4'hC, $urandom, 0, 1, 0, 0, 1);
        add_row(0, 4'hC, 0, 0, 1, 0, 0, 1);
        add_row(1, ioexp_pkg::REG_STATUS, 32'h1, 0, 1, 0, 0, 1);
        add_row(1, ioexp_pkg::REG_OUT0, {16'($urandom), r0b}, 0, 0, 1, ioexp_pkg::EXP0_ADDR, 0);
        add_row(1, ioexp_pkg::REG_OUT1, {16'($urandom), r1b}, 0, 0, 1, ioexp_pkg::EXP1_ADDR, 0);
        // both updates are still on the bus, so status reads busy.
        add_row(0, ioexp_pkg::REG_STATUS, 0, 32'h1, 0, 0, 0, 1);
        add_row(0, ioexp_pkg::REG_OUT0, 0, {16'h0, r0b}, 0, 0, 0, 1);
        add_row(0, ioexp_pkg::REG_OUT1, 0, {16'h0, r1b}, 0, 0, 0, 1);
        add_row(1, ioexp_pkg::REG_OUT1, {16'($urandom), r1c}, 0, 0, 1, ioexp_pkg::EXP1_ADDR, 1);
        add_row(0, ioexp_pkg::REG_OUT1, 0, {16'h0, r1c}, 0, 0, 0, 1);

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait_idle();

        foreach (rows[i]) begin
            if (rows[i].has_frame) begin
                u_checker.expect_frame({rows[i].dev, ioexp_pkg::CMD_OUTPUT,
                                        rows[i].wdata[7:0], rows[i].wdata[15:8]});
            end
            u_checker.expect_apb(!rows[i].wr, rows[i].exp_err, rows[i].exp_rdata);
            apb_access(rows[i].wr, rows[i].addr, rows[i].wdata, rd);
            if (rows[i].wait_after) begin
                wait_idle();
            end
        end

        u_checker.final_check();
        @(negedge clk);
        $display("errors: %0d in I2C frames, %0d in APB responses", frame_errors, apb_errors);
        if (frame_errors == 0 && apb_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
common/i2c_pkg.sv
common/ioexp_pkg.sv
hw/ioexp_apb_regs.sv
i2c_ioexp/i2c_master_wr.sv
i2c_ioexp/i2c_ioexp.sv
hw/ioexp_subsys_top.sv
verif/ioexp_checker.sv
verif/tb_ioexp.sv

// File: Bender.yml
package:
  name: ioexp_subsys

sources:
  - common/i2c_pkg.sv
  - common/ioexp_pkg.sv
  - hw/ioexp_apb_regs.sv
  - i2c_ioexp/i2c_master_wr.sv
  - i2c_ioexp/i2c_ioexp.sv
  - hw/ioexp_subsys_top.sv
  - target: test
    files:
      - verif/ioexp_checker.sv
      - verif/tb_ioexp.sv
